// File: include/icmu_consts.svh
// icmu constants: page geometry, context word width and credit depths
`ifndef ICMU_CONSTS_SVH
`define ICMU_CONSTS_SVH

// context pages in the store
`define ICMU_NUM_PAGES 4

// context slots held by each page
`define ICMU_PAGE_SLOTS 8

// width of one saved context word
`define ICMU_DW 32

// request queue depth, also the requester's starting credit count
`define ICMU_REQ_CREDITS 4

// response credits the consumer grants at reset
`define ICMU_RSP_CREDITS 2

`endif

// File: run_sim.sh
#!/bin/sh
# compile the icmu testbench with Verilator, run it and look for the pass line

verilator --binary -f verilog.f --top-module icmu_tb -Mdir obj_dir -o icmu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/icmu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: src/ctx_bus_if.sv
// ctx_bus_if: issued context requests from the queue head into the page store
`timescale 1ns/10ps

interface ctx_bus_if;
    import icmu_pkg::*;

    logic      valid;  // one transfer per cycle while high
    ctx_op_e   op;
    level_t    level;
    slot_t     slot;
    ctx_word_t data;   // only meaningful for saves

    // The store takes every issued item, so there is no ready path back.
    modport ctrl (
        output valid,
        output op,
        output level,
        output slot,
        output data
    );

    modport store (
        input valid,
        input op,
        input level,
        input slot,
        input data
    );

endinterface

// File: src/icmu_ctx_store.sv
// icmu context store: two-stage paged storage, page lookup then slot write or read
`timescale 1ns/10ps
`include "icmu_consts.svh"

module icmu_ctx_store (
    input  logic                clk,
    input  logic                rst_n,
    ctx_bus_if.store            bus,
    input  icmu_pkg::page_map_t page_map,
    output logic                rsp_valid,
    output icmu_pkg::level_t    rsp_level,
    output icmu_pkg::slot_t     rsp_slot,
    output icmu_pkg::ctx_word_t rsp_data
);
    import icmu_pkg::*;

    // stage 1 holding registers
    logic      s1_valid;
    ctx_op_e   s1_op;
    level_t    s1_level;
    slot_t     s1_slot;
    ctx_word_t s1_data;
    page_t     s1_page;  // resolved at issue time

    logic s1_save;
    logic s1_restore;

    ctx_word_t ctx_mem [`ICMU_NUM_PAGES][`ICMU_PAGE_SLOTS];

    assign s1_save    = s1_valid && (s1_op == CTX_SAVE);
    assign s1_restore = s1_valid && (s1_op == CTX_RESTORE);

    // stage 1: register the issued item and look up its page
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            s1_valid <= 1'b0;
        else
            s1_valid <= bus.valid;
    end

    always_ff @(posedge clk) begin
        if (bus.valid) begin
            s1_op    <= bus.op;
            s1_level <= bus.level;
            s1_slot  <= bus.slot;
            s1_data  <= bus.data;
            s1_page  <= page_map[bus.level];
        end
    end

    // Stage 2 commits saves in issue order. A restore issued right behind a
    // save to the same slot reaches this stage one cycle after the write has
    // landed, so it always reads the new word.
    always_ff @(posedge clk) begin
        if (s1_save)
            ctx_mem[s1_page][s1_slot] <= s1_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= s1_restore;  // saves produce no response
    end

    always_ff @(posedge clk) begin
        if (s1_restore) begin
            rsp_level <= s1_level;
            rsp_slot  <= s1_slot;
            rsp_data  <= ctx_mem[s1_page][s1_slot];
        end
    end

endmodule

// File: src/icmu_page_cfg.sv
// icmu page config: per-level page map register, written through the config port
`timescale 1ns/10ps

module icmu_page_cfg (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cfg_wr,
    input  icmu_pkg::level_t    cfg_level,
    input  icmu_pkg::page_t     cfg_page,
    output icmu_pkg::page_map_t page_map
);
    import icmu_pkg::*;

    // Page switching is addressable per level here: one config write moves
    // a single interrupt level onto another page and leaves the rest alone.
    // Two levels may share a page after a remap, in which case their
    // contexts alias in the store.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < $size(page_map); i++) begin
                page_map[i] <= page_t'(i);  // identity, level n on page n
            end
        end else if (cfg_wr) begin
            page_map[cfg_level] <= cfg_page;  // visible from the next cycle
        end
    end

endmodule

// File: src/icmu_pkg.sv
// icmu types: request opcode, level, page, slot, context word and page map
`include "icmu_consts.svh"

package icmu_pkg;

    // request opcode carried with every request
    typedef enum logic {
        CTX_SAVE    = 1'b0,  // write one word into a slot
        CTX_RESTORE = 1'b1   // read one word back out
    } ctx_op_e;

    typedef logic [1:0] level_t;  // four interrupt levels

    typedef logic [$clog2(`ICMU_NUM_PAGES)-1:0] page_t;

    typedef logic [$clog2(`ICMU_PAGE_SLOTS)-1:0] slot_t;

    typedef logic [`ICMU_DW-1:0] ctx_word_t;

    // one page index per interrupt level, indexed by level
    typedef page_t [2**$bits(level_t)-1:0] page_map_t;

endpackage

// File: src/icmu_req_ctrl.sv
// icmu request controller: credit-fed request queue with in-order issue to the store
`timescale 1ns/10ps
`include "icmu_consts.svh"

module icmu_req_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    input  icmu_pkg::ctx_op_e   req_op,
    input  icmu_pkg::level_t    req_level,
    input  icmu_pkg::slot_t     req_slot,
    input  icmu_pkg::ctx_word_t req_data,
    input  logic                rsp_credit,
    output logic                req_credit,
    ctx_bus_if.ctrl             bus
);
    import icmu_pkg::*;

    localparam int DEPTH = `ICMU_REQ_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int RSP_W = $clog2(`ICMU_RSP_CREDITS + 1);

    ctx_op_e   q_op    [DEPTH];
    level_t    q_level [DEPTH];
    slot_t     q_slot  [DEPTH];
    ctx_word_t q_data  [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] q_count;
    logic [RSP_W-1:0] rsp_cnt;   // response credits still held
    logic             issue;
    logic             restore_issue;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        ptr_next = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // a restore at the head waits for a response credit, later items wait behind it
    assign issue         = (q_count != '0) && ((q_op[rd_ptr] == CTX_SAVE) || (rsp_cnt != '0));
    assign restore_issue = issue && (q_op[rd_ptr] == CTX_RESTORE);

    assign bus.valid  = issue;
    assign bus.op     = q_op[rd_ptr];
    assign bus.level  = q_level[rd_ptr];
    assign bus.slot   = q_slot[rd_ptr];
    assign bus.data   = q_data[rd_ptr];
    assign req_credit = issue;  // entry freed, requester gets its credit back

    // requester never sends without credit, so no full check
    always_ff @(posedge clk) begin
        if (req_valid) begin
            q_op[wr_ptr]    <= req_op;
            q_level[wr_ptr] <= req_level;
            q_slot[wr_ptr]  <= req_slot;
            q_data[wr_ptr]  <= req_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else begin
            if (req_valid)
                wr_ptr <= ptr_next(wr_ptr);
            if (issue)
                rd_ptr <= ptr_next(rd_ptr);
            case ({req_valid, issue})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;  // idle or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_cnt <= RSP_W'(`ICMU_RSP_CREDITS);
        end else begin
            case ({rsp_credit, restore_issue})
                2'b10:   rsp_cnt <= rsp_cnt + 1'b1;
                2'b01:   rsp_cnt <= rsp_cnt - 1'b1;
                default: rsp_cnt <= rsp_cnt;
            endcase
        end
    end

endmodule

// File: src/icmu_top.sv
// icmu top: interrupt context management unit, request queue, page map and store
`timescale 1ns/10ps

module icmu_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    input  icmu_pkg::ctx_op_e   req_op,
    input  icmu_pkg::level_t    req_level,
    input  icmu_pkg::slot_t     req_slot,
    input  icmu_pkg::ctx_word_t req_data,
    output logic                req_credit,
    output logic                rsp_valid,
    output icmu_pkg::level_t    rsp_level,
    output icmu_pkg::slot_t     rsp_slot,
    output icmu_pkg::ctx_word_t rsp_data,
    input  logic                rsp_credit,
    input  logic                cfg_wr,
    input  icmu_pkg::level_t    cfg_level,
    input  icmu_pkg::page_t     cfg_page
);
    import icmu_pkg::*;

    page_map_t page_map;  // current level to page assignment

    ctx_bus_if bus_i ();

    icmu_req_ctrl req_ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_level  (req_level),
        .req_slot   (req_slot),
        .req_data   (req_data),
        .rsp_credit (rsp_credit),
        .req_credit (req_credit),
        .bus        (bus_i.ctrl)
    );

    icmu_page_cfg page_cfg_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_wr    (cfg_wr),
        .cfg_level (cfg_level),
        .cfg_page  (cfg_page),
        .page_map  (page_map)
    );

    icmu_ctx_store ctx_store_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (bus_i.store),
        .page_map  (page_map),
        .rsp_valid (rsp_valid),
        .rsp_level (rsp_level),
        .rsp_slot  (rsp_slot),
        .rsp_data  (rsp_data)
    );

endmodule

// File: testbench/icmu_tb.sv
// icmu testbench: save, restore, remap and credit flow checked against a reference model
`timescale 1ns/10ps
`include "icmu_consts.svh"

module icmu_tb;
    import icmu_pkg::*;

    localparam int WAIT_LIMIT = 200;  // cycles allowed per wait loop
    localparam int EXP_DEPTH  = 1024;
    localparam int SEED       = 32'h86bd;

    logic      clk;
    logic      rst_n;
    logic      req_valid;
    ctx_op_e   req_op;
    level_t    req_level;
    slot_t     req_slot;
    ctx_word_t req_data;
    logic      req_credit;
    logic      rsp_valid;
    level_t    rsp_level;
    slot_t     rsp_slot;
    ctx_word_t rsp_data;
    logic      rsp_credit;
    logic      cfg_wr;
    level_t    cfg_level;
    page_t     cfg_page;

    integer seed     = SEED;  // stimulus
    integer rsp_seed = SEED;  // consumer delays

    // reference model
    page_t     ref_map [4];
    ctx_word_t ref_mem [`ICMU_NUM_PAGES][`ICMU_PAGE_SLOTS];
    level_t    exp_level [EXP_DEPTH];
    slot_t     exp_slot  [EXP_DEPTH];
    ctx_word_t exp_data  [EXP_DEPTH];
    int        exp_wr;         // written at request time
    int        exp_rd;         // advanced by the compare process
    int        req_sent;
    int        credit_pulses;
    int        rsp_count;
    int        rsp_errors;
    int        seq_errors;
    logic      hold_credits;   // consumer withholds rsp_credit while set
    int        due_q [$];      // cycles at which response credits go back
    bit        stalled;        // a wait loop ran out of cycles

    icmu_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic ctx_word_t ref_restore(input level_t lvl, input slot_t s);
        return ref_mem[ref_map[lvl]][s];  // word last saved to the level's current page
    endfunction

    function automatic int credits_left();
        return `ICMU_REQ_CREDITS + credit_pulses - req_sent;
    endfunction

    function automatic bit all_idle();
        return credits_left() >= `ICMU_REQ_CREDITS && exp_rd == exp_wr && due_q.size() == 0;
    endfunction

    // stimulus stops here for good, the watchdog ends the run
    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s at %0t", what, $time);
        seq_errors++;
        stalled = 1'b1;
        forever @(posedge clk);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_req(input ctx_op_e op, input level_t lvl, input slot_t s,
                            input ctx_word_t data);
        int waited;
        waited = 0;
        while (credits_left() == 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (credits_left() == 0)
            report_timeout("a request credit");
        req_valid = 1'b1;
        req_op    = op;
        req_level = lvl;
        req_slot  = s;
        req_data  = data;
        req_sent++;
        if (op == CTX_SAVE) begin
            ref_mem[ref_map[lvl]][s] = data;
        end else begin
            exp_level[exp_wr] = lvl;
            exp_slot[exp_wr]  = s;
            exp_data[exp_wr]  = ref_restore(lvl, s);
            exp_wr++;
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic drain(input string what);
        int waited;
        waited = 0;
        while (!all_idle() && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!all_idle())
            report_timeout(what);
    endtask

    task automatic write_map(input level_t lvl, input page_t pg);
        cfg_wr    = 1'b1;
        cfg_level = lvl;
        cfg_page  = pg;
        @(posedge clk);
        #1;
        cfg_wr       = 1'b0;
        ref_map[lvl] = pg;  // used from the next request on
    endtask

    initial begin : watchdog
        wait (stalled);
        $display("errors: response %0d, sequence %0d", rsp_errors, seq_errors);
        $display("TEST FAIL");
        $finish;
    end

    // consumer: hands a response credit back 0 to 3 cycles after each response
    initial begin : consumer
        int delay;
        int cycle_cnt;
        rsp_credit = 1'b0;
        cycle_cnt  = 0;
        forever begin
            @(posedge clk);
            cycle_cnt++;
            if (rst_n && rsp_valid) begin
                delay = $random(rsp_seed) & 3;
                due_q.push_back(cycle_cnt + delay);
            end
            #1;
            if (!hold_credits && due_q.size() != 0 && due_q[0] <= cycle_cnt) begin
                void'(due_q.pop_front());
                rsp_credit = 1'b1;
            end else begin
                rsp_credit = 1'b0;
            end
        end
    end

    // compare process
    always @(posedge clk) begin
        if (rst_n) begin
            if (req_credit)
                credit_pulses++;
            if (req_sent == 0) begin
                assert (!req_credit && !rsp_valid) else begin
                    rsp_errors++;
                    $display("CHECK FAILED at %0t: output active before first request", $time);
                end
            end
            if (rsp_valid)
                rsp_count++;
            if (rsp_valid && exp_rd == exp_wr) begin
                rsp_errors++;
                $display("response at %0t arrived with no restore outstanding", $time);
            end else if (rsp_valid) begin
                assert (rsp_level == exp_level[exp_rd] && rsp_slot == exp_slot[exp_rd]) else begin
                    rsp_errors++;
                    $display("CHECK FAILED at %0t: level/slot %0d/%0d, expected %0d/%0d", $time,
                             rsp_level, rsp_slot, exp_level[exp_rd], exp_slot[exp_rd]);
                end
                assert (rsp_data == exp_data[exp_rd]) else begin
                    rsp_errors++;
                    $display("CHECK FAILED at %0t: data %h, expected %h", $time,
                             rsp_data, exp_data[exp_rd]);
                end
                exp_rd++;
            end
        end
    end

    initial begin
        logic [31:0] r;
        int          held_base;
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req_op       = CTX_SAVE;
        req_level    = '0;
        req_slot     = '0;
        req_data     = '0;
        cfg_wr       = 1'b0;
        cfg_level    = '0;
        cfg_page     = '0;
        hold_credits = 1'b0;
        for (int l = 0; l < 4; l++)
            ref_map[l] = page_t'(l);
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle_cycles(3);

        for (int l = 0; l < 4; l++)
            for (int s = 0; s < `ICMU_PAGE_SLOTS; s++)
                send_req(CTX_SAVE, level_t'(l), slot_t'(s), ctx_word_t'($random(seed)));
        for (int l = 0; l < 4; l++)
            for (int s = 0; s < `ICMU_PAGE_SLOTS; s++)
                send_req(CTX_RESTORE, level_t'(l), slot_t'(s), '0);
        drain("identity map responses");

        write_map(2'd1, 2'd3);  // level 1 now shares page 3 with level 3
        for (int s = 0; s < `ICMU_PAGE_SLOTS; s++)
            send_req(CTX_RESTORE, 2'd1, slot_t'(s), '0);
        send_req(CTX_SAVE, 2'd1, 3'd2, ctx_word_t'($random(seed)));
        send_req(CTX_RESTORE, 2'd3, 3'd2, '0);
        drain("remapped responses");

        hold_credits = 1'b1;
        held_base    = rsp_count;
        for (int i = 0; i < 4; i++)
            send_req(CTX_RESTORE, 2'd0, slot_t'(i), '0);
        idle_cycles(16);
        assert (rsp_count - held_base <= `ICMU_RSP_CREDITS) else begin
            seq_errors++;
            $display("CHECK FAILED at %0t: %0d responses without credit return", $time,
                     rsp_count - held_base);
        end
        hold_credits = 1'b0;
        drain("responses after credit return");

        for (int i = 0; i < 120; i++) begin
            r = $random(seed);
            if (r[1:0] == 2'b00) begin  // same slot saved then restored back to back
                send_req(CTX_SAVE, r[5:4], r[8:6], ctx_word_t'($random(seed)));
                send_req(CTX_RESTORE, r[5:4], r[8:6], '0);
            end else begin
                send_req(ctx_op_e'(r[2]), r[5:4], r[8:6], ctx_word_t'($random(seed)));
            end
        end
        drain("random mix responses");

        assert (credit_pulses == req_sent) else begin
            seq_errors++;
            $display("CHECK FAILED at %0t: %0d credit pulses for %0d requests", $time,
                     credit_pulses, req_sent);
        end
        $display("errors: response %0d, sequence %0d", rsp_errors, seq_errors);
        if (rsp_errors == 0 && seq_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
src/icmu_pkg.sv
src/ctx_bus_if.sv
src/icmu_req_ctrl.sv
src/icmu_page_cfg.sv
src/icmu_ctx_store.sv
src/icmu_top.sv
testbench/icmu_tb.sv
